//--- irq_consts.svh
`ifndef IRQ_CONSTS_SVH
`define IRQ_CONSTS_SVH

// interrupt unit sizes, fixed by the cpu architecture

// level 0 is the nmi, level 31 the lowest
`define IRQ_LEVELS 32

// rm register, one bit per mask group
`define IRQ_MASK_BITS 10

// level number width
`define IRQ_VEC_BITS 5

`endif

//--- irq_pkg.sv
`include "irq_consts.svh"

package irq_pkg;

	// one bit per level, bit n is level n
	typedef logic [`IRQ_LEVELS-1:0] level_vec_t;

	// mask register; bit 0 gates level 1, bit 9 gates levels 28..31
	typedef logic [`IRQ_MASK_BITS-1:0] mask_reg_t;

	// level number, also the vector handed to the cpu
	typedef logic [`IRQ_VEC_BITS-1:0] vec_num_t;

	// software write word, same bit order as level_vec_t
	// low bits double as the mask value on a mask write
	typedef logic [`IRQ_LEVELS-1:0] wr_data_t;

	// group index of a mask bit, 0..9
	typedef logic [3:0] mask_grp_t;

endpackage

//--- irq_source_front.sv
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_source_front import irq_pkg::*; (
	input  logic       __clk,
	input  logic       rst_n,
	input  level_vec_t irq_lines,      // async lines, request on rising edge
	input  logic       mask_wr,        // load mask from wr_data low bits
	input  logic       req_set_wr,     // software set of request bits
	input  logic       req_clr_wr,     // software clear of request bits
	input  wr_data_t   wr_data,
	input  logic       mask_clr_pulse, // accept happened one cycle ago
	input  vec_num_t   mask_clr_level, // level that was accepted
	output level_vec_t set_req,
	output level_vec_t clr_req,
	output level_vec_t level_en,
	output mask_reg_t  mask_bits
);

	// mask group of a level
	// level 0 has no group and maps to 0 so its accept wipes the whole mask
	function automatic mask_grp_t group_of(input vec_num_t lvl);
		mask_grp_t g;
		if (lvl == 5'd0) begin
			g = 4'd0;
		end else if (lvl <= 5'd4) begin
			g = mask_grp_t'(lvl - 5'd1); // one bit per level
		end else if (lvl <= 5'd11) begin
			g = 4'd4;
		end else if (lvl <= 5'd13) begin
			g = 4'd5;
		end else if (lvl <= 5'd15) begin
			g = 4'd6;
		end else if (lvl <= 5'd21) begin
			g = 4'd7;
		end else if (lvl <= 5'd27) begin
			g = 4'd8;
		end else begin
			g = 4'd9;
		end
		return g;
	endfunction

	level_vec_t sync_a;    // first sync stage may go metastable
	level_vec_t sync_b;    // second sync stage
	level_vec_t sync_c;    // previous value for edge detect
	level_vec_t line_edge; // one-cycle pulse per rising line
	level_vec_t sw_set_q;  // registered software set word
	level_vec_t sw_clr_q;  // registered software clear word
	mask_grp_t  clr_group;
	mask_reg_t  mask_clr_bits;
	mask_reg_t  mask_next;

	// two-flop synchronizer then edge detect on the request lines
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			sync_a <= '0;
			sync_b <= '0;
			sync_c <= '0;
		end else begin
			sync_a <= irq_lines;
			sync_b <= sync_a;
			sync_c <= sync_b;
		end
	end

	assign line_edge = sync_b & ~sync_c; // held line fires once

	// software writes reach the cells one edge later
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			sw_set_q <= '0;
			sw_clr_q <= '0;
		end else begin
			sw_set_q <= req_set_wr ? wr_data : '0;
			sw_clr_q <= req_clr_wr ? wr_data : '0;
		end
	end

	// clear beats set on the same bit
	assign clr_req = sw_clr_q;
	assign set_req = (line_edge | sw_set_q) & ~sw_clr_q;

	// groups at and below the accepted level get masked
	assign clr_group = group_of(mask_clr_level);

	always_comb begin
		mask_clr_bits = '0;
		for (int i = 0; i < `IRQ_MASK_BITS; i++) begin
			if (mask_clr_pulse && (mask_grp_t'(i) >= clr_group)) begin
				mask_clr_bits[i] = 1'b1;
			end
		end
	end

	// accept clear wins over a mask write
	assign mask_next = (mask_wr ? wr_data[`IRQ_MASK_BITS-1:0] : mask_bits) & ~mask_clr_bits;

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			mask_bits <= '0; // all masked so only nmi is live
		end else begin
			mask_bits <= mask_next;
		end
	end

	// expand rm to one enable per level
	assign level_en = {
		{4{mask_bits[9]}}, // 28..31
		{6{mask_bits[8]}}, // 22..27
		{6{mask_bits[7]}}, // 16..21
		{2{mask_bits[6]}}, // 14..15
		{2{mask_bits[5]}}, // 12..13
		{7{mask_bits[4]}}, // 5..11
		mask_bits[3:0],    // 1..4
		1'b1               // level 0 never masked
	};

	// the cells see no set/clear conflict
	a_no_set_clr: assert property (@(posedge __clk) disable iff (!rst_n)
		(set_req & clr_req) == '0);

endmodule

//--- irq_cell.sv
`timescale 1ns/1ps

module irq_cell import irq_pkg::*; (
	input  logic __clk,
	input  logic rst_n,
	input  logic set_req,   // conflict-free from the front
	input  logic clr_req,
	input  logic level_en,  // mask group enable
	input  logic ack,       // cpu accepts the winner
	input  logic rti,       // cpu returns from the ret level
	input  logic grant_in,  // no higher level pending
	input  logic ret_in,    // no higher level in service
	output logic grant_out,
	output logic ret_out,
	output logic win,
	output logic ret,
	output logic pend_en,
	output logic req_bit
);

	logic req_q; // rz
	logic svc_q; // rp

	assign pend_en   = req_q & level_en;
	assign win       = pend_en & grant_in;  // highest enabled request
	assign grant_out = grant_in & ~pend_en; // pass on only when idle
	assign ret       = svc_q & ret_in;      // highest level in service
	assign ret_out   = ret_in & ~svc_q;
	assign req_bit   = req_q;

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			req_q <= 1'b0;
		end else if (ack && win) begin
			req_q <= 1'b0; // accept beats a set
		end else if (clr_req) begin
			req_q <= 1'b0;
		end else if (set_req) begin
			req_q <= 1'b1;
		end
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			svc_q <= 1'b0;
		end else if (ack && win) begin
			svc_q <= 1'b1; // request moves into service
		end else if (rti && ret) begin
			svc_q <= 1'b0;
		end
	end

	a_win_pend: assert property (@(posedge __clk) disable iff (!rst_n)
		win |-> pend_en);

endmodule

//--- irq_vector_encoder.sv
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_vector_encoder import irq_pkg::*; (
	input  logic       __clk,
	input  logic       rst_n,
	input  logic       ack,
	input  level_vec_t win,            // one-hot winner from the grant chain
	input  level_vec_t pend_en,        // enabled requests, all levels
	output logic       irq,            // registered OR of enabled requests
	output vec_num_t   vector,
	output logic       vector_valid,   // one cycle
	output logic       mask_clr_pulse, // mask clear in the front next edge
	output vec_num_t   mask_clr_level
);

	vec_num_t win_num;
	logic     any_win;
	logic     take;

	// one-hot to binary by OR of the winner's index bits
	always_comb begin
		win_num = '0;
		for (int i = 0; i < `IRQ_LEVELS; i++) begin
			if (win[i]) begin
				win_num = win_num | vec_num_t'(i);
			end
		end
	end

	assign any_win = |win;
	assign take    = ack & any_win; // ack with nothing pending is dropped

	// control flops
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			irq            <= 1'b0;
			mask_clr_pulse <= 1'b0;
			vector_valid   <= 1'b0;
		end else begin
			irq            <= |pend_en;
			mask_clr_pulse <= take;
			vector_valid   <= mask_clr_pulse; // second stage after accept
		end
	end

	// accepted level first, vector one edge later
	always_ff @(posedge __clk) begin
		if (take) begin
			mask_clr_level <= win_num;
		end
		if (mask_clr_pulse) begin
			vector <= mask_clr_level;
		end
	end

	// grant chain allows a single winner at most
	a_win_onehot: assert property (@(posedge __clk) disable iff (!rst_n)
		$onehot0(win));

	// vector is a pulse that is never held
	a_vec_pulse: assert property (@(posedge __clk) disable iff (!rst_n)
		vector_valid |=> !vector_valid);

endmodule

//--- irq_unit.sv
`timescale 1ns/1ps
`include "irq_consts.svh"

module irq_unit import irq_pkg::*; (
	input  logic       __clk,
	input  logic       rst_n,
	input  level_vec_t irq_lines,    // async request lines
	input  logic       mask_wr,
	input  logic       req_set_wr,
	input  logic       req_clr_wr,
	input  wr_data_t   wr_data,
	input  logic       ack,          // accept pulse
	input  logic       rti,          // return pulse
	output logic       irq,
	output vec_num_t   vector,
	output logic       vector_valid,
	output level_vec_t req_bits,     // rz readback
	output mask_reg_t  mask_bits     // rm readback
);

	level_vec_t set_req;
	level_vec_t clr_req;
	level_vec_t level_en;
	level_vec_t win;
	level_vec_t ret;
	level_vec_t pend_en;
	level_vec_t grant_in;  // grant chain, level 0 first
	level_vec_t grant_out;
	level_vec_t ret_in;    // return chain, same order
	level_vec_t ret_out;
	logic       mask_clr_pulse;
	vec_num_t   mask_clr_level;

	// both chains start open at level 0 and ripple down
	assign grant_in = {grant_out[`IRQ_LEVELS-2:0], 1'b1};
	assign ret_in   = {ret_out[`IRQ_LEVELS-2:0], 1'b1};

	irq_source_front front_i (
		.__clk          (__clk),
		.rst_n          (rst_n),
		.irq_lines      (irq_lines),
		.mask_wr        (mask_wr),
		.req_set_wr     (req_set_wr),
		.req_clr_wr     (req_clr_wr),
		.wr_data        (wr_data),
		.mask_clr_pulse (mask_clr_pulse),
		.mask_clr_level (mask_clr_level),
		.set_req        (set_req),
		.clr_req        (clr_req),
		.level_en       (level_en),
		.mask_bits      (mask_bits)
	);

	// rz/rp pair per level
	for (genvar i = 0; i < `IRQ_LEVELS; i++) begin : gen_cell
		irq_cell cell_i (
			.__clk     (__clk),
			.rst_n     (rst_n),
			.set_req   (set_req[i]),
			.clr_req   (clr_req[i]),
			.level_en  (level_en[i]),
			.ack       (ack),
			.rti       (rti),
			.grant_in  (grant_in[i]),
			.ret_in    (ret_in[i]),
			.grant_out (grant_out[i]),
			.ret_out   (ret_out[i]),
			.win       (win[i]),
			.ret       (ret[i]),
			.pend_en   (pend_en[i]),
			.req_bit   (req_bits[i])
		);
	end

	irq_vector_encoder encoder_i (
		.__clk          (__clk),
		.rst_n          (rst_n),
		.ack            (ack),
		.win            (win),
		.pend_en        (pend_en),
		.irq            (irq),
		.vector         (vector),
		.vector_valid   (vector_valid),
		.mask_clr_pulse (mask_clr_pulse),
		.mask_clr_level (mask_clr_level)
	);

	// at most one level leaves service per return
	a_ret_onehot: assert property (@(posedge __clk) disable iff (!rst_n)
		$onehot0(ret));

endmodule

//--- tb_irq_unit.sv
`timescale 1ns/1ps

module tb_irq_unit import irq_pkg::*; ();

	logic       __clk;
	logic       rst_n;
	level_vec_t irq_lines;
	logic       mask_wr;
	logic       req_set_wr;
	logic       req_clr_wr;
	wr_data_t   wr_data;
	logic       ack;
	logic       rti;
	logic       irq;
	vec_num_t   vector;
	logic       vector_valid;
	level_vec_t req_bits;
	mask_reg_t  mask_bits;

	// one entry per case line
	string       op_q[$];
	logic [31:0] data_q[$];
	logic [31:0] req_q[$];
	logic [31:0] mask_q[$];
	logic [31:0] vec_q[$];
	logic [31:0] irq_q[$];
	logic [31:0] flag_q[$]; // 1 req, 2 mask, 4 vector expected, 8 irq

	int          n_cases = 0;
	int          n_errors = 0;
	int          n_checks = 0;
	logic        loaded = 1'b0;
	int          vv_count;  // vector_valid pulses seen in one operation
	logic [31:0] vec_seen;

	irq_unit irq_unit_i (
		.__clk        (__clk),
		.rst_n        (rst_n),
		.irq_lines    (irq_lines),
		.mask_wr      (mask_wr),
		.req_set_wr   (req_set_wr),
		.req_clr_wr   (req_clr_wr),
		.wr_data      (wr_data),
		.ack          (ack),
		.rti          (rti),
		.irq          (irq),
		.vector       (vector),
		.vector_valid (vector_valid),
		.req_bits     (req_bits),
		.mask_bits    (mask_bits)
	);

	always #2 __clk = ~__clk; // 4 ns period

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
		end
	endtask

	// parse the cases file, comment lines start with #
	task load_cases;
		int          fd;
		int          n;
		string       line;
		string       op;
		logic [31:0] d, r, m, v, i, fl;
		fd = $fopen("irq_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open irq_cases.txt");
			n_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#") continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h", op, d, r, m, v, i, fl);
			if (n != 7) begin
				$display("case line could not be parsed: %s", line);
				n_errors++;
				continue;
			end
			op_q.push_back(op);
			data_q.push_back(d);
			req_q.push_back(r);
			mask_q.push_back(m);
			vec_q.push_back(v);
			irq_q.push_back(i);
			flag_q.push_back(fl);
		end
		$fclose(fd);
	endtask

	// vector is a one-cycle pulse, so catch it on every falling edge
	task watch_vector;
		if (vector_valid === 1'b1) begin
			vv_count++;
			vec_seen = 32'(vector);
		end
	endtask

	task run_op(input int idx);
		string op;
		int    settle; // edges until the rule says the effect has landed
		int    gap;
		op = op_q[idx];
		gap = $urandom_range(0, 3);
		repeat (gap) @(posedge __clk); // random idle gap
		@(posedge __clk);
		settle = 2;
		case (op)
			"mask": begin
				mask_wr <= 1'b1;
				wr_data <= data_q[idx];
			end
			"set": begin
				req_set_wr <= 1'b1;
				wr_data <= data_q[idx];
				settle = 3; // front register, then cell, then irq
			end
			"clr": begin
				req_clr_wr <= 1'b1;
				wr_data <= data_q[idx];
				settle = 3;
			end
			"setclr": begin
				req_set_wr <= 1'b1; // same bit, same cycle
				req_clr_wr <= 1'b1;
				wr_data <= data_q[idx];
				settle = 3;
			end
			"line": begin
				irq_lines <= data_q[idx]; // held until the next line op
				settle = 4;                // two sync flops, edge, cell, irq
			end
			"ack": begin
				ack <= 1'b1;
				settle = 4; // covers the vector pulse window
			end
			"rti": rti <= 1'b1;
			"idle": ;
			default: begin
				$display("unknown opcode %s in case %0d", op, idx);
				n_errors++;
			end
		endcase
		@(posedge __clk);
		mask_wr <= 1'b0; // strobes last one cycle
		req_set_wr <= 1'b0;
		req_clr_wr <= 1'b0;
		ack <= 1'b0;
		rti <= 1'b0;
		vv_count = 0;
		vec_seen = '0;
		repeat (settle - 1) begin
			@(negedge __clk);
			watch_vector();
			@(posedge __clk);
		end
		@(negedge __clk); // outputs stable mid cycle
		watch_vector();
		if (flag_q[idx][0]) check_value("req_bits", req_bits, req_q[idx]);
		if (flag_q[idx][1]) check_value("mask_bits", 32'(mask_bits), mask_q[idx]);
		if (flag_q[idx][3]) check_value("irq", 32'(irq), irq_q[idx]);
		if (flag_q[idx][2]) begin
			check_value("vector_valid pulses", 32'(vv_count), 32'd1);
			check_value("vector", vec_seen, vec_q[idx]);
		end else begin
			check_value("vector_valid pulses", 32'(vv_count), 32'd0); // no accept expected
		end
	endtask

	initial begin
		__clk = 1'b0;
		rst_n = 1'b0;
		irq_lines = '0;
		mask_wr = 1'b0;
		req_set_wr = 1'b0;
		req_clr_wr = 1'b0;
		wr_data = '0;
		ack = 1'b0;
		rti = 1'b0;
		vv_count = 0;
		vec_seen = '0;
		void'($urandom(97551));
		load_cases();
		n_cases = op_q.size();
		loaded = 1'b1;
		repeat (5) @(posedge __clk);
		rst_n <= 1'b1;
		for (int k = 0; k < n_cases; k++) begin
			run_op(k);
		end
		repeat (2) @(posedge __clk);
		$display("cases: %0d  checks: %0d  errors: %0d", n_cases, n_checks, n_errors);
		if (n_errors == 0 && n_cases > 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog, 20 cycles per case plus the reset
	initial begin
		wait (loaded === 1'b1);
		repeat (n_cases * 20 + 5) @(posedge __clk);
		$display("timeout: the cases did not finish within %0d cycles", n_cases * 20 + 5);
		$display("cases: %0d  checks: %0d  errors: %0d", n_cases, n_checks, n_errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- irq_cases.txt
# op data req_bits mask_bits vector irq flags, all hex
# flags: 1 req_bits, 2 mask_bits, 4 vector pulse expected, 8 irq
# reset state, masked level 5 stays quiet, level 0 fires
idle   00000000 00000000 000 00 0 b
set    00000020 00000020 000 00 0 b
set    00000001 00000021 000 00 1 b
ack    00000000 00000020 000 00 0 f
rti    00000000 00000020 000 00 0 b
clr    00000020 00000000 000 00 0 b
# priority, levels 3 9 30 with the full mask
mask   000003ff 00000000 3ff 00 0 b
set    40000208 40000208 3ff 00 1 b
ack    00000000 40000200 003 03 0 f
# level 9 now masked, ack finds nothing
ack    00000000 40000200 003 00 0 b
# return and re-enable
mask   000003ff 40000200 3ff 00 1 b
rti    00000000 40000200 3ff 00 1 b
ack    00000000 40000000 00f 09 0 f
mask   000003ff 40000000 3ff 00 1 b
ack    00000000 00000000 1ff 1e 0 f
rti    00000000 00000000 1ff 00 0 b
rti    00000000 00000000 1ff 00 0 b
# line 7 held high sets once
line   00000080 00000080 1ff 00 1 b
idle   00000000 00000080 1ff 00 1 b
clr    00000080 00000000 1ff 00 0 b
idle   00000000 00000000 1ff 00 0 b
idle   00000000 00000000 1ff 00 0 b
line   00000000 00000000 1ff 00 0 b
# set and clear in one cycle
setclr 00001000 00000000 1ff 00 0 b
set    00001000 00001000 1ff 00 1 b
setclr 00001000 00000000 1ff 00 0 b
ack    00000000 00000000 1ff 00 0 b
# line on level 0, its accept wipes the mask
line   00000001 00000001 1ff 00 1 b
ack    00000000 00000000 000 00 0 f
rti    00000000 00000000 000 00 0 b
line   00000000 00000000 000 00 0 b

//--- src.f
+incdir+.
irq_pkg.sv
irq_source_front.sv
irq_cell.sv
irq_vector_encoder.sv
irq_unit.sv
tb_irq_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the irq_unit testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_irq_unit -o sim_irq_unit

# a crash of the simulator stops the script here
./obj_dir/sim_irq_unit > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0
